//--- logic/mips_pkg.sv
package mips_pkg;

  // Primary opcodes, instr[31:26]
  localparam logic [5:0] OP_RTYPE  = 6'h00;
  localparam logic [5:0] OP_REGIMM = 6'h01; // BLTZ, BGEZ and link forms
  localparam logic [5:0] OP_BEQ    = 6'h04;
  localparam logic [5:0] OP_BNE    = 6'h05;
  localparam logic [5:0] OP_BLEZ   = 6'h06;
  localparam logic [5:0] OP_BGTZ   = 6'h07;
  localparam logic [5:0] OP_ADDIU  = 6'h09;
  localparam logic [5:0] OP_SLTI   = 6'h0a;
  localparam logic [5:0] OP_SLTIU  = 6'h0b;
  localparam logic [5:0] OP_ANDI   = 6'h0c;
  localparam logic [5:0] OP_ORI    = 6'h0d;
  localparam logic [5:0] OP_XORI   = 6'h0e;
  localparam logic [5:0] OP_LUI    = 6'h0f;
  localparam logic [5:0] OP_LB     = 6'h20;
  localparam logic [5:0] OP_LH     = 6'h21;
  localparam logic [5:0] OP_LWL    = 6'h22;
  localparam logic [5:0] OP_LW     = 6'h23;
  localparam logic [5:0] OP_LBU    = 6'h24;
  localparam logic [5:0] OP_LHU    = 6'h25;
  localparam logic [5:0] OP_LWR    = 6'h26;
  localparam logic [5:0] OP_SB     = 6'h28;
  localparam logic [5:0] OP_SH     = 6'h29;
  localparam logic [5:0] OP_SW     = 6'h2b;

  // R-type function codes, instr[5:0]
  localparam logic [5:0] FN_SLL   = 6'h00;
  localparam logic [5:0] FN_SRL   = 6'h02;
  localparam logic [5:0] FN_SRA   = 6'h03;
  localparam logic [5:0] FN_SLLV  = 6'h04;
  localparam logic [5:0] FN_SRLV  = 6'h06;
  localparam logic [5:0] FN_SRAV  = 6'h07;
  localparam logic [5:0] FN_MFHI  = 6'h10;
  localparam logic [5:0] FN_MTHI  = 6'h11;
  localparam logic [5:0] FN_MFLO  = 6'h12;
  localparam logic [5:0] FN_MTLO  = 6'h13;
  localparam logic [5:0] FN_MULT  = 6'h18;
  localparam logic [5:0] FN_MULTU = 6'h19;
  localparam logic [5:0] FN_DIV   = 6'h1a;
  localparam logic [5:0] FN_DIVU  = 6'h1b;
  localparam logic [5:0] FN_ADDU  = 6'h21;
  localparam logic [5:0] FN_SUBU  = 6'h23;
  localparam logic [5:0] FN_AND   = 6'h24;
  localparam logic [5:0] FN_OR    = 6'h25;
  localparam logic [5:0] FN_XOR   = 6'h26;
  localparam logic [5:0] FN_SLTU  = 6'h2b;
  localparam logic [5:0] FN_SLT   = 6'h2a;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fields_t;

  // Same word seen as R-type or I-type
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_word_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    MD_MULT, MD_MULTU, MD_DIV, MD_DIVU, MD_MTHI, MD_MTLO
  } md_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
  } br_cond_e;

endpackage

//--- logic/exec_if.sv
interface exec_if;

  mips_pkg::alu_op_e  alu_op;
  logic [31:0]        opnd_a;    // Always rs
  logic [31:0]        opnd_b;    // rt or extended immediate
  logic [4:0]         shamt;
  logic               shamt_sel; // High selects rs[4:0]
  logic [31:0]        alu_out;

  mips_pkg::br_cond_e br_cond;
  logic               taken;

  mips_pkg::md_op_e   md_op;
  logic               md_start;  // One cycle per accepted HI/LO op
  logic [31:0]        md_a;
  logic [31:0]        md_b;
  logic [31:0]        hi;
  logic [31:0]        lo;
  logic               md_busy;

  modport ctrl (
    output alu_op, opnd_a, opnd_b, shamt, shamt_sel, br_cond, md_op, md_start, md_a, md_b,
    input  alu_out, taken, hi, lo, md_busy
  );
  modport alu (input alu_op, opnd_a, opnd_b, shamt, shamt_sel, output alu_out);
  modport branch (input br_cond, opnd_a, opnd_b, output taken);
  modport muldiv (input md_op, md_start, md_a, md_b, output hi, lo, md_busy);

endinterface

//--- logic/exec_control.sv
module exec_control (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue,
  input  mips_pkg::instr_word_u instr,
  input  logic [31:0]           rs_val,
  input  logic [31:0]           rt_val,
  output logic                  ready,
  output logic [31:0]           result,
  output logic                  result_valid,
  output logic                  branch_taken,
  output logic                  illegal,
  exec_if.ctrl                  bus
);

  logic        accept;
  logic [31:0] imm_sext;
  logic [31:0] imm_zext;
  logic [31:0] res_d;
  logic        rd_hi;
  logic        rd_lo;
  logic        md_dec;  // Goes to the HI/LO unit, no result
  logic        bad;

  assign ready        = !bus.md_busy; // Blocked only by a running divide
  assign accept       = issue && ready;
  assign imm_sext     = {{16{instr.i.imm[15]}}, instr.i.imm};
  assign imm_zext     = {16'h0000, instr.i.imm};
  assign bus.opnd_a   = rs_val;
  assign bus.shamt    = instr.r.shamt;
  assign bus.md_a     = rs_val;
  assign bus.md_b     = rt_val;
  assign bus.md_start = accept && md_dec;

  always_comb
  begin
    bus.alu_op    = mips_pkg::ALU_ADD;
    bus.opnd_b    = rt_val;
    bus.shamt_sel = 1'b0;
    bus.br_cond   = mips_pkg::BR_NONE;
    bus.md_op     = mips_pkg::MD_MULT;
    rd_hi         = 1'b0;
    rd_lo         = 1'b0;
    md_dec        = 1'b0;
    bad           = 1'b0;
    case (instr.r.opcode)
      mips_pkg::OP_RTYPE:
        case (instr.r.funct)
          mips_pkg::FN_ADDU: bus.alu_op = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUBU: bus.alu_op = mips_pkg::ALU_SUB;
          mips_pkg::FN_AND:  bus.alu_op = mips_pkg::ALU_AND;
          mips_pkg::FN_OR:   bus.alu_op = mips_pkg::ALU_OR;
          mips_pkg::FN_XOR:  bus.alu_op = mips_pkg::ALU_XOR;
          mips_pkg::FN_SLT:  bus.alu_op = mips_pkg::ALU_SLT;
          mips_pkg::FN_SLTU: bus.alu_op = mips_pkg::ALU_SLTU;
          mips_pkg::FN_SLL:  bus.alu_op = mips_pkg::ALU_SLL;
          mips_pkg::FN_SRL:  bus.alu_op = mips_pkg::ALU_SRL;
          mips_pkg::FN_SRA:  bus.alu_op = mips_pkg::ALU_SRA;
          mips_pkg::FN_SLLV, mips_pkg::FN_SRLV, mips_pkg::FN_SRAV:
          begin
            bus.shamt_sel = 1'b1; // Amount from rs
            if (instr.r.funct == mips_pkg::FN_SLLV)
              bus.alu_op = mips_pkg::ALU_SLL;
            else if (instr.r.funct == mips_pkg::FN_SRLV)
              bus.alu_op = mips_pkg::ALU_SRL;
            else
              bus.alu_op = mips_pkg::ALU_SRA;
          end
          mips_pkg::FN_MFHI: rd_hi = 1'b1;
          mips_pkg::FN_MFLO: rd_lo = 1'b1;
          mips_pkg::FN_MULT, mips_pkg::FN_MULTU, mips_pkg::FN_DIV, mips_pkg::FN_DIVU,
          mips_pkg::FN_MTHI, mips_pkg::FN_MTLO:
          begin
            md_dec = 1'b1;
            case (instr.r.funct)
              mips_pkg::FN_MULTU: bus.md_op = mips_pkg::MD_MULTU;
              mips_pkg::FN_DIV:   bus.md_op = mips_pkg::MD_DIV;
              mips_pkg::FN_DIVU:  bus.md_op = mips_pkg::MD_DIVU;
              mips_pkg::FN_MTHI:  bus.md_op = mips_pkg::MD_MTHI;
              mips_pkg::FN_MTLO:  bus.md_op = mips_pkg::MD_MTLO;
              default:            bus.md_op = mips_pkg::MD_MULT;
            endcase
          end
          default: bad = 1'b1;
        endcase
      // rt of 0, 1, 16 and 17 only; bit 0 picks GEZ
      mips_pkg::OP_REGIMM:
        if (instr.i.rt[3:1] == 3'b000)
          bus.br_cond = instr.i.rt[0] ? mips_pkg::BR_GEZ : mips_pkg::BR_LTZ;
        else
          bad = 1'b1;
      mips_pkg::OP_BEQ:  bus.br_cond = mips_pkg::BR_EQ;
      mips_pkg::OP_BNE:  bus.br_cond = mips_pkg::BR_NE;
      mips_pkg::OP_BLEZ: bus.br_cond = mips_pkg::BR_LEZ;
      mips_pkg::OP_BGTZ: bus.br_cond = mips_pkg::BR_GTZ;
      mips_pkg::OP_SLTI:
      begin
        bus.alu_op = mips_pkg::ALU_SLT;
        bus.opnd_b = imm_sext;
      end
      mips_pkg::OP_SLTIU:
      begin
        bus.alu_op = mips_pkg::ALU_SLTU;
        bus.opnd_b = imm_sext; // Sign extended, then compared unsigned
      end
      mips_pkg::OP_ANDI:
      begin
        bus.alu_op = mips_pkg::ALU_AND;
        bus.opnd_b = imm_zext;
      end
      mips_pkg::OP_ORI:
      begin
        bus.alu_op = mips_pkg::ALU_OR;
        bus.opnd_b = imm_zext;
      end
      mips_pkg::OP_XORI:
      begin
        bus.alu_op = mips_pkg::ALU_XOR;
        bus.opnd_b = imm_zext;
      end
      mips_pkg::OP_LUI:
      begin
        bus.alu_op = mips_pkg::ALU_LUI;
        bus.opnd_b = imm_zext;
      end
      // ADDIU and every load or store address
      mips_pkg::OP_ADDIU, mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LWL,
      mips_pkg::OP_LW, mips_pkg::OP_LBU, mips_pkg::OP_LHU, mips_pkg::OP_LWR,
      mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW:
        bus.opnd_b = imm_sext;
      default: bad = 1'b1;
    endcase
  end

  always_comb
  begin
    if (rd_hi)
      res_d = bus.hi;
    else if (rd_lo)
      res_d = bus.lo;
    else if (bad || bus.br_cond != mips_pkg::BR_NONE)
      res_d = '0; // Branches and illegal words report zero
    else
      res_d = bus.alu_out;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      result_valid <= 1'b0;
      branch_taken <= 1'b0;
      illegal      <= 1'b0;
    end
    else
    begin
      result_valid <= accept && !md_dec;
      branch_taken <= accept && bus.taken;
      illegal      <= accept && bad;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept && !md_dec)
      result <= res_d;
  end

endmodule

//--- logic/int_alu.sv
module int_alu (
  exec_if.alu bus
);

  logic [4:0] sh_amt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Variable shifts use only rs[4:0]
  assign sh_amt      = bus.shamt_sel ? bus.opnd_a[4:0] : bus.shamt;
  assign lt_signed   = $signed(bus.opnd_a) < $signed(bus.opnd_b);
  assign lt_unsigned = bus.opnd_a < bus.opnd_b;

  always_comb
  begin
    case (bus.alu_op)
      mips_pkg::ALU_ADD:  bus.alu_out = bus.opnd_a + bus.opnd_b;
      mips_pkg::ALU_SUB:  bus.alu_out = bus.opnd_a - bus.opnd_b;
      mips_pkg::ALU_AND:  bus.alu_out = bus.opnd_a & bus.opnd_b;
      mips_pkg::ALU_OR:   bus.alu_out = bus.opnd_a | bus.opnd_b;
      mips_pkg::ALU_XOR:  bus.alu_out = bus.opnd_a ^ bus.opnd_b;
      mips_pkg::ALU_SLL:  bus.alu_out = bus.opnd_b << sh_amt;
      mips_pkg::ALU_SRL:  bus.alu_out = bus.opnd_b >> sh_amt;
      mips_pkg::ALU_SRA:  bus.alu_out = $signed(bus.opnd_b) >>> sh_amt; // Sign fill
      mips_pkg::ALU_SLT:  bus.alu_out = {31'b0, lt_signed};
      mips_pkg::ALU_SLTU: bus.alu_out = {31'b0, lt_unsigned};
      mips_pkg::ALU_LUI:  bus.alu_out = {bus.opnd_b[15:0], 16'h0000};
      default:            bus.alu_out = '0;
    endcase
  end

endmodule

//--- logic/branch_unit.sv
module branch_unit (
  exec_if.branch bus
);

  logic rs_neg;
  logic rs_zero;

  assign rs_neg  = bus.opnd_a[31];
  assign rs_zero = (bus.opnd_a == '0);

  // Link forms arrive here as their plain condition
  always_comb
  begin
    case (bus.br_cond)
      mips_pkg::BR_EQ:  bus.taken = (bus.opnd_a == bus.opnd_b);
      mips_pkg::BR_NE:  bus.taken = (bus.opnd_a != bus.opnd_b);
      mips_pkg::BR_LEZ: bus.taken = rs_neg || rs_zero;
      mips_pkg::BR_GTZ: bus.taken = !rs_neg && !rs_zero;
      mips_pkg::BR_LTZ: bus.taken = rs_neg;
      mips_pkg::BR_GEZ: bus.taken = !rs_neg;
      default:          bus.taken = 1'b0;
    endcase
  end

endmodule

//--- logic/hilo_unit.sv
module hilo_unit #(
  parameter int DIV_BITS_PER_CYCLE = 1
) (
  input  logic   clk,
  input  logic   rst,
  exec_if.muldiv bus
);

  localparam int DIV_STEPS = 32 / DIV_BITS_PER_CYCLE;

  logic [31:0] hi_q;
  logic [31:0] lo_q;
  logic        busy;
  logic [5:0]  step_cnt;
  logic [32:0] rem_q;    // Partial remainder, one spare bit for the shift
  logic [32:0] rem_nxt;
  logic [31:0] quo_q;    // Dividend shifts out, quotient shifts in
  logic [31:0] quo_nxt;
  logic [31:0] dsr_q;
  logic        neg_quo;
  logic        neg_rem;
  logic        signed_op;
  logic        a_neg;
  logic        b_neg;
  logic [31:0] a_mag;
  logic [31:0] b_mag;
  logic [63:0] product;

  assign bus.hi      = hi_q;
  assign bus.lo      = lo_q;
  assign bus.md_busy = busy;

  assign signed_op = (bus.md_op == mips_pkg::MD_MULT) || (bus.md_op == mips_pkg::MD_DIV);
  assign a_neg     = signed_op && bus.md_a[31];
  assign b_neg     = signed_op && bus.md_b[31];
  assign a_mag     = a_neg ? -bus.md_a : bus.md_a;
  assign b_mag     = b_neg ? -bus.md_b : bus.md_b;

  always_comb
  begin
    if (bus.md_op == mips_pkg::MD_MULT)
      product = $signed(bus.md_a) * $signed(bus.md_b);
    else
      product = bus.md_a * bus.md_b;
  end

  // Restoring steps; a zero divisor yields all ones and the dividend
  always_comb
  begin
    rem_nxt = rem_q;
    quo_nxt = quo_q;
    for (int k = 0; k < DIV_BITS_PER_CYCLE; k++)
    begin
      rem_nxt = {rem_nxt[31:0], quo_nxt[31]};
      quo_nxt = {quo_nxt[30:0], 1'b0};
      if (rem_nxt >= {1'b0, dsr_q})
      begin
        rem_nxt    = rem_nxt - {1'b0, dsr_q};
        quo_nxt[0] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hi_q     <= '0;
      lo_q     <= '0;
      busy     <= 1'b0;
      step_cnt <= '0;
    end
    else if (busy)
    begin
      step_cnt <= step_cnt - 6'd1;
      if (step_cnt == 6'd1)
      begin
        busy <= 1'b0;
        hi_q <= neg_rem ? -rem_nxt[31:0] : rem_nxt[31:0]; // Dividend's sign
        lo_q <= neg_quo ? -quo_nxt : quo_nxt;
      end
    end
    else if (bus.md_start)
    begin
      case (bus.md_op)
        mips_pkg::MD_MULT, mips_pkg::MD_MULTU: {hi_q, lo_q} <= product;
        mips_pkg::MD_MTHI: hi_q <= bus.md_a;
        mips_pkg::MD_MTLO: lo_q <= bus.md_a;
        default:
        begin
          busy     <= 1'b1;
          step_cnt <= 6'(DIV_STEPS);
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (busy)
    begin
      rem_q <= rem_nxt;
      quo_q <= quo_nxt;
    end
    else if (bus.md_start)
    begin
      rem_q   <= '0;
      quo_q   <= a_mag;
      dsr_q   <= b_mag;
      neg_quo <= a_neg ^ b_neg;
      neg_rem <= a_neg;
    end
  end

endmodule

//--- logic/exec_stage.sv
module exec_stage #(
  parameter int DIV_BITS_PER_CYCLE = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        issue,
  input  logic [31:0] instr,
  input  logic [31:0] rs_val,
  input  logic [31:0] rt_val,
  output logic        ready,
  output logic [31:0] result,
  output logic        result_valid,
  output logic        branch_taken,
  output logic        illegal
);

  exec_if bus ();

  exec_control u_control (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .instr        (instr),
    .rs_val       (rs_val),
    .rt_val       (rt_val),
    .ready        (ready),
    .result       (result),
    .result_valid (result_valid),
    .branch_taken (branch_taken),
    .illegal      (illegal),
    .bus          (bus.ctrl)
  );

  int_alu u_alu (
    .bus (bus.alu)
  );

  branch_unit u_branch (
    .bus (bus.branch)
  );

  hilo_unit #(
    .DIV_BITS_PER_CYCLE (DIV_BITS_PER_CYCLE)
  ) u_hilo (
    .clk (clk),
    .rst (rst),
    .bus (bus.muldiv)
  );

endmodule

//--- test/exec_stage_asserts.sv
module exec_stage_asserts #(
  parameter int DIV_BITS_PER_CYCLE = 2
) (
  input logic        clk,
  input logic        rst,
  input logic        issue,
  input logic [31:0] instr,
  input logic        ready,
  input logic        result_valid,
  input logic        branch_taken,
  input logic        illegal
);

  localparam int DIV_CYCLES = 32 / DIV_BITS_PER_CYCLE;

  int   fail_count = 0;
  logic is_md;
  logic is_div;
  logic accept;

  // Words that go to HI/LO and give no result
  assign is_md  = (instr[31:26] == mips_pkg::OP_RTYPE) &&
                  (instr[5:0] inside {mips_pkg::FN_MULT, mips_pkg::FN_MULTU, mips_pkg::FN_DIV,
                                      mips_pkg::FN_DIVU, mips_pkg::FN_MTHI, mips_pkg::FN_MTLO});
  assign is_div = (instr[31:26] == mips_pkg::OP_RTYPE) &&
                  (instr[5:0] inside {mips_pkg::FN_DIV, mips_pkg::FN_DIVU});
  assign accept = issue && ready;

  result_follows_issue: assert property (
    @(posedge clk) disable iff (rst) accept && !is_md |=> result_valid)
  else
  begin
    fail_count++;
    $error("result_valid missing one cycle after an accepted issue");
  end

  result_needs_issue: assert property (
    @(posedge clk) disable iff (rst) result_valid |-> $past(accept && !is_md))
  else
  begin
    fail_count++;
    $error("result_valid without a matching accepted issue");
  end

  illegal_has_valid: assert property (
    @(posedge clk) disable iff (rst) illegal |-> result_valid)
  else
  begin
    fail_count++;
    $error("illegal raised without result_valid");
  end

  ready_low_for_divide: assert property (
    @(posedge clk) disable iff (rst) accept && is_div |=> !ready [*DIV_CYCLES] ##1 ready)
  else
  begin
    fail_count++;
    $error("ready low for the wrong number of cycles during a divide");
  end

  ready_falls_on_divide: assert property (
    @(posedge clk) disable iff (rst) $fell(ready) |-> $past(accept && is_div))
  else
  begin
    fail_count++;
    $error("ready fell without an accepted divide");
  end

  quiet_after_reset: assert property (
    @(posedge clk) $past(rst) |-> ready && !result_valid && !branch_taken && !illegal)
  else
  begin
    fail_count++;
    $error("Outputs not at reset values after reset");
  end

endmodule

bind exec_stage exec_stage_asserts #(
  .DIV_BITS_PER_CYCLE (DIV_BITS_PER_CYCLE)
) u_asserts (.*);

//--- test/exec_stage_tb.sv
module exec_stage_tb;

  localparam int READY_LIMIT  = 100;
  localparam int RESULT_LIMIT = 10;

  logic        clk;
  logic        rst;
  logic        issue;
  logic [31:0] instr;
  logic [31:0] rs_val;
  logic [31:0] rt_val;
  logic        ready;
  logic [31:0] result;
  logic        result_valid;
  logic        branch_taken;
  logic        illegal;

  exec_stage DUT (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .instr        (instr),
    .rs_val       (rs_val),
    .rt_val       (rt_val),
    .ready        (ready),
    .result       (result),
    .result_valid (result_valid),
    .branch_taken (branch_taken),
    .illegal      (illegal)
  );

  always #4 clk = ~clk;

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] sh);
    return {mips_pkg::OP_RTYPE, 5'd1, 5'd2, 5'd3, sh, funct};
  endfunction

  function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                             input logic [15:0] imm);
    return {op, 5'd1, rt, imm};
  endfunction

  function automatic logic [31:0] rtype_model(input logic [5:0] funct, input logic [31:0] a,
                                              input logic [31:0] b, input logic [4:0] sh);
    case (funct)
      mips_pkg::FN_ADDU: return a + b;
      mips_pkg::FN_SUBU: return a - b;
      mips_pkg::FN_AND:  return a & b;
      mips_pkg::FN_OR:   return a | b;
      mips_pkg::FN_XOR:  return a ^ b;
      mips_pkg::FN_SLL:  return b << sh;
      mips_pkg::FN_SRL:  return b >> sh;
      mips_pkg::FN_SRA:  return $signed(b) >>> sh;
      mips_pkg::FN_SLLV: return b << a[4:0]; // Amount from rs
      mips_pkg::FN_SRLV: return b >> a[4:0];
      mips_pkg::FN_SRAV: return $signed(b) >>> a[4:0];
      mips_pkg::FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      mips_pkg::FN_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:           return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] itype_model(input logic [5:0] op, input logic [31:0] a,
                                              input logic [15:0] imm);
    logic [31:0] se;
    logic [31:0] ze;
    se = {{16{imm[15]}}, imm};
    ze = {16'h0000, imm};
    case (op)
      mips_pkg::OP_SLTI:  return ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
      mips_pkg::OP_SLTIU: return (a < se) ? 32'd1 : 32'd0; // Unsigned against sign extended
      mips_pkg::OP_ANDI:  return a & ze;
      mips_pkg::OP_ORI:   return a | ze;
      mips_pkg::OP_XORI:  return a ^ ze;
      mips_pkg::OP_LUI:   return {imm, 16'h0000};
      default:            return a + se; // ADDIU and load/store address
    endcase
  endfunction

  function automatic logic taken_model(input logic [31:0] w, input logic [31:0] a,
                                       input logic [31:0] b);
    case (w[31:26])
      mips_pkg::OP_BEQ:  return a == b;
      mips_pkg::OP_BNE:  return a != b;
      mips_pkg::OP_BLEZ: return $signed(a) <= 0;
      mips_pkg::OP_BGTZ: return $signed(a) > 0;
      default:           return w[16] ? ($signed(a) >= 0) : ($signed(a) < 0); // REGIMM
    endcase
  endfunction

  function automatic logic [63:0] product_model(input logic sgn, input logic [31:0] a,
                                                input logic [31:0] b);
    if (sgn)
      return {{32{a[31]}}, a} * {{32{b[31]}}, b};
    return {32'h0, a} * {32'h0, b};
  endfunction

  // Magnitudes first, signs applied last
  task automatic divide_model(input logic sgn, input logic [31:0] a, input logic [31:0] b,
                              output logic [31:0] q, output logic [31:0] r);
    logic        an;
    logic        bn;
    logic [31:0] am;
    logic [31:0] bm;
    logic [31:0] qm;
    logic [31:0] rm;
    an = sgn && a[31];
    bn = sgn && b[31];
    am = an ? -a : a;
    bm = bn ? -b : b;
    if (bm == 0)
    begin
      qm = 32'hffff_ffff;
      rm = am;
    end
    else
    begin
      qm = am / bm;
      rm = am % bm;
    end
    q = (an ^ bn) ? -qm : qm;
    r = an ? -rm : rm;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready)
    begin
      @(negedge clk);
      n++;
      if (n > READY_LIMIT)
      begin
        $display("Timed out waiting for ready to return high");
        abort_run();
      end
    end
  endtask

  task automatic execute_op(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
                            output logic [31:0] res, output logic tkn, output logic ill);
    int n;
    wait_ready();
    instr  = w;
    rs_val = a;
    rt_val = b;
    issue  = 1'b1;
    @(negedge clk);
    issue = 1'b0;
    n = 1;
    while (!result_valid)
    begin
      if (n >= RESULT_LIMIT)
      begin
        $display("Timed out waiting for result_valid after an issue");
        abort_run();
      end
      @(negedge clk);
      n++;
    end
    check_value("result latency", n, 1);
    res = result;
    tkn = branch_taken;
    ill = illegal;
  endtask

  // HI/LO writes give no result strobe
  task automatic send_op(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b);
    wait_ready();
    instr  = w;
    rs_val = a;
    rt_val = b;
    issue  = 1'b1;
    @(negedge clk);
    issue = 1'b0;
    check_value("result_valid after HI/LO op", result_valid, 1'b0);
  endtask

  task automatic read_hilo(input logic [31:0] exp_hi, input logic [31:0] exp_lo);
    logic [31:0] res;
    logic        tkn;
    logic        ill;
    execute_op(rtype_word(mips_pkg::FN_MFHI, 5'd0), 32'h0, 32'h0, res, tkn, ill);
    check_value("MFHI result", res, exp_hi);
    execute_op(rtype_word(mips_pkg::FN_MFLO, 5'd0), 32'h0, 32'h0, res, tkn, ill);
    check_value("MFLO result", res, exp_lo);
  endtask

  task automatic alu_case(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] exp);
    logic [31:0] res;
    logic        tkn;
    logic        ill;
    execute_op(w, a, b, res, tkn, ill);
    check_value($sformatf("result of %h", w), res, exp);
    check_value("branch_taken on ALU op", tkn, 1'b0);
    check_value("illegal on ALU op", ill, 1'b0);
  endtask

  task automatic branch_case(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    logic        tkn;
    logic        ill;
    execute_op(w, a, b, res, tkn, ill);
    check_value($sformatf("branch_taken of %h rs %h rt %h", w, a, b), tkn, taken_model(w, a, b));
    check_value("branch result", res, 32'h0);
    check_value("illegal on branch", ill, 1'b0);
  endtask

  task automatic divide_case(input logic sgn, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] q;
    logic [31:0] r;
    divide_model(sgn, a, b, q, r);
    send_op(rtype_word(sgn ? mips_pkg::FN_DIV : mips_pkg::FN_DIVU, 5'd0), a, b);
    wait_ready();
    read_hilo(r, q);
  endtask

  task automatic reset_behavior();
    check_value("ready after reset", ready, 1'b1);
    check_value("result_valid after reset", result_valid, 1'b0);
    check_value("branch_taken after reset", branch_taken, 1'b0);
    check_value("illegal after reset", illegal, 1'b0);
    read_hilo(32'h0, 32'h0);
  endtask

  task automatic rtype_ops();
    logic [5:0]  functs [13];
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    functs = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR,
               mips_pkg::FN_XOR, mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA,
               mips_pkg::FN_SLLV, mips_pkg::FN_SRLV, mips_pkg::FN_SRAV, mips_pkg::FN_SLT,
               mips_pkg::FN_SLTU};
    foreach (functs[f])
    begin
      for (int k = 0; k < 5; k++)
      begin
        a  = $urandom();
        b  = $urandom();
        sh = $urandom();
        if (k == 0)
        begin
          a  = 32'hffff_ffdf; // Low five bits give 31
          b  = 32'h8000_7001;
          sh = 5'd31;
        end
        else if (k == 1)
        begin
          a  = 32'h0000_0005;
          b  = 32'hffff_fff0;
          sh = 5'd0;
        end
        alu_case(rtype_word(functs[f], sh), a, b, rtype_model(functs[f], a, b, sh));
      end
    end
  endtask

  task automatic itype_ops();
    logic [5:0]  ops [15];
    logic [31:0] a;
    logic [15:0] imm;
    ops = '{mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI,
            mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI, mips_pkg::OP_LB,
            mips_pkg::OP_LH, mips_pkg::OP_LW, mips_pkg::OP_LBU, mips_pkg::OP_LHU,
            mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW};
    foreach (ops[o])
    begin
      for (int k = 0; k < 4; k++)
      begin
        a   = $urandom();
        imm = $urandom();
        if (k == 0)
        begin
          a   = 32'h0000_1000;
          imm = 16'h8000;
        end
        else if (k == 1)
        begin
          a   = 32'hffff_fff8;
          imm = 16'hfff0;
        end
        alu_case(itype_word(ops[o], 5'd2, imm), a, 32'h5a5a_5a5a, itype_model(ops[o], a, imm));
      end
    end
  endtask

  task automatic branch_conditions();
    logic [31:0] words [8];
    logic [31:0] vals [4];
    words = '{itype_word(mips_pkg::OP_BEQ, 5'd2, 16'h0010),
              itype_word(mips_pkg::OP_BNE, 5'd2, 16'h0010),
              itype_word(mips_pkg::OP_BLEZ, 5'd0, 16'hfff0),
              itype_word(mips_pkg::OP_BGTZ, 5'd0, 16'hfff0),
              itype_word(mips_pkg::OP_REGIMM, 5'd0, 16'h0004),  // BLTZ
              itype_word(mips_pkg::OP_REGIMM, 5'd1, 16'h0004),  // BGEZ
              itype_word(mips_pkg::OP_REGIMM, 5'd16, 16'h0004), // BLTZAL
              itype_word(mips_pkg::OP_REGIMM, 5'd17, 16'h0004)};
    vals = '{32'h0000_0000, 32'h0000_0005, 32'hffff_fffb, 32'h8000_0000};
    foreach (words[w])
    begin
      foreach (vals[v])
      begin
        branch_case(words[w], vals[v], vals[v]);
        branch_case(words[w], vals[v], vals[v] ^ 32'h0000_0010);
      end
    end
  endtask

  task automatic hilo_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] p;
    for (int k = 0; k < 6; k++)
    begin
      a = (k == 0) ? 32'hffff_fffd : $urandom();
      b = (k == 0) ? 32'h0000_0007 : $urandom();
      p = product_model(k[0], a, b);
      send_op(rtype_word(k[0] ? mips_pkg::FN_MULT : mips_pkg::FN_MULTU, 5'd0), a, b);
      read_hilo(p[63:32], p[31:0]);
    end
    for (int s = 0; s < 2; s++)
    begin
      divide_case(s[0], 32'd100, 32'd7);
      divide_case(s[0], -32'sd100, 32'd7);
      divide_case(s[0], 32'd100, -32'sd7);
      divide_case(s[0], -32'sd100, -32'sd7);
      divide_case(s[0], 32'h8000_0000, 32'hffff_ffff);
      divide_case(s[0], 32'd1234, 32'd0);
      divide_case(s[0], -32'sd1234, 32'd0);
      divide_case(s[0], $urandom(), $urandom() >> 12);
    end
    send_op(rtype_word(mips_pkg::FN_MTHI, 5'd0), 32'h1357_9bdf, 32'h1111_1111);
    send_op(rtype_word(mips_pkg::FN_MTLO, 5'd0), 32'h2468_ace0, 32'h2222_2222);
    read_hilo(32'h1357_9bdf, 32'h2468_ace0);
  endtask

  task automatic backpressure_and_illegal();
    logic [31:0] q;
    logic [31:0] r;
    logic [31:0] res;
    logic [31:0] bad_words [3];
    logic        tkn;
    logic        ill;
    int          n;
    divide_model(1'b1, 32'hffff_fc18, 32'd33, q, r); // -1000 / 33
    send_op(rtype_word(mips_pkg::FN_DIV, 5'd0), 32'hffff_fc18, 32'd33);
    check_value("ready during divide", ready, 1'b0);
    instr  = rtype_word(mips_pkg::FN_ADDU, 5'd0); // Dropped, divider busy
    rs_val = 32'h0000_0001;
    rt_val = 32'h0000_0002;
    issue  = 1'b1;
    @(negedge clk);
    instr  = rtype_word(mips_pkg::FN_MTLO, 5'd0); // Also dropped
    rs_val = 32'hdead_beef;
    @(negedge clk);
    issue = 1'b0;
    n = 0;
    while (!ready)
    begin
      check_value("result_valid while divide runs", result_valid, 1'b0);
      @(negedge clk);
      n++;
      if (n > READY_LIMIT)
      begin
        $display("Timed out waiting for the divide to finish");
        abort_run();
      end
    end
    check_value("result_valid after divide", result_valid, 1'b0);
    read_hilo(r, q);
    bad_words = '{32'hfc22_0005,
                  rtype_word(6'h3f, 5'd0),
                  itype_word(mips_pkg::OP_REGIMM, 5'd2, 16'h0004)};
    foreach (bad_words[i])
    begin
      execute_op(bad_words[i], 32'h0000_0005, 32'h0000_0006, res, tkn, ill);
      check_value("illegal flag", ill, 1'b1);
      check_value("illegal result", res, 32'h0);
      check_value("branch_taken on illegal", tkn, 1'b0);
    end
  endtask

  initial
  begin
    int seed_dummy;
    seed_dummy = $urandom(32'h8f4d_cc1e);
    clk    = 1'b0;
    rst    = 1'b1;
    issue  = 1'b0;
    instr  = 32'h0;
    rs_val = 32'h0;
    rt_val = 32'h0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    reset_behavior();
    rtype_ops();
    itype_ops();
    branch_conditions();
    hilo_ops();
    backpressure_and_illegal();
    repeat (2) @(negedge clk);
    if (DUT.u_asserts.fail_count != 0)
    begin
      $display("Bound assertions reported %0d failures", DUT.u_asserts.fail_count);
      abort_run();
    end
    else
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

//--- list.f
logic/mips_pkg.sv
logic/exec_if.sv
logic/exec_control.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/hilo_unit.sv
logic/exec_stage.sv
test/exec_stage_asserts.sv
test/exec_stage_tb.sv
